// ==== gb_cpu_common_pkg.sv ====
package gb_cpu_common_pkg;

    ////////////////////////////////////////
    // register and operation codes
    ////////////////////////////////////////

    // 8-bit register field, same order as the opcode bits
    typedef enum logic [2:0] {
        REG_B  = 3'd0,
        REG_C  = 3'd1,
        REG_D  = 3'd2,
        REG_E  = 3'd3,
        REG_H  = 3'd4,
        REG_L  = 3'd5,
        REG_HL = 3'd6,  // memory operand, never written here
        REG_A  = 3'd7
    } r8_t;

    // low codes follow opcode bits so the decoder can cast them directly
    typedef enum logic [4:0] {
        // accumulator ops, opcode bits 5:3
        ADD  = 5'd0,  ADC  = 5'd1,  SUB  = 5'd2,  SBC  = 5'd3,
        AND  = 5'd4,  XOR  = 5'd5,  OR   = 5'd6,  CP   = 5'd7,
        // cb rotates and shifts, opcode bits 5:3
        RLC  = 5'd8,  RRC  = 5'd9,  RL   = 5'd10, RR   = 5'd11,
        SLA  = 5'd12, SRA  = 5'd13, SWAP = 5'd14, SRL  = 5'd15,
        // bit, res, set follow cb opcode bits 7:6
        INC  = 5'd16, BIT  = 5'd17, RES  = 5'd18, SET  = 5'd19,
        DEC  = 5'd20, CPL  = 5'd21, SCF  = 5'd22, CCF  = 5'd23,
        PASS = 5'd24  // loads
    } alu_op_t;

    // bit positions inside F
    localparam int FLAG_Z = 7;
    localparam int FLAG_N = 6;
    localparam int FLAG_H = 5;
    localparam int FLAG_C = 4;

    ////////////////////////////////////////
    // control and datapath bundles
    ////////////////////////////////////////

    typedef struct packed {
        logic       valid;         // decoded to a real operation
        alu_op_t    alu_op;
        r8_t        dst;           // operand a and write target
        r8_t        src;           // operand b unless immediate
        logic       use_imm;       // operand b is the next byte
        logic [2:0] bit_idx;       // bit, res, set
        logic       write_result;
        logic       write_flags;
        logic       keep_z;        // rlca/rrca/rla/rra: z forced low
        logic       cb_next;       // prefix byte, cb opcode follows
        logic       halt;
    } schedule_t;

    typedef struct packed {
        schedule_t  sched;
        logic [7:0] imm8;
    } exec_t;

    typedef struct packed {
        logic       we;
        r8_t        dst;
        logic [7:0] data;
        logic       flags_we;
        logic [7:0] flags;
    } wb_t;

endpackage : gb_cpu_common_pkg

// ==== gb_cpu_decoder.sv ====
module gb_cpu_decoder (
    input  logic [7:0]                   opcode,
    input  logic                         cb_prefix,
    output gb_cpu_common_pkg::schedule_t schedule
);

    gb_cpu_common_pkg::r8_t     r8_hi;   // opcode bits 5:3
    gb_cpu_common_pkg::r8_t     r8_lo;   // opcode bits 2:0
    gb_cpu_common_pkg::alu_op_t acc_op;  // add .. cp
    gb_cpu_common_pkg::alu_op_t shf_op;  // rlc .. srl
    gb_cpu_common_pkg::alu_op_t bsr_op;  // bit, res, set

    assign r8_hi  = gb_cpu_common_pkg::r8_t'(opcode[5:3]);
    assign r8_lo  = gb_cpu_common_pkg::r8_t'(opcode[2:0]);
    assign acc_op = gb_cpu_common_pkg::alu_op_t'({2'b00, opcode[5:3]});
    assign shf_op = gb_cpu_common_pkg::alu_op_t'({2'b01, opcode[5:3]});
    assign bsr_op = gb_cpu_common_pkg::alu_op_t'({3'b100, opcode[7:6]});

    ////////////////////////////////////////
    // schedule builders
    ////////////////////////////////////////

    function automatic gb_cpu_common_pkg::schedule_t empty_schedule();
        return '0;
    endfunction

    function automatic gb_cpu_common_pkg::schedule_t load8_bit(
        gb_cpu_common_pkg::r8_t dst,
        gb_cpu_common_pkg::r8_t src = gb_cpu_common_pkg::REG_A,
        logic use_imm = 1'b0
    );
        gb_cpu_common_pkg::schedule_t s;
        s              = empty_schedule();
        s.valid        = 1'b1;
        s.alu_op       = gb_cpu_common_pkg::PASS;
        s.dst          = dst;
        s.src          = src;
        s.use_imm      = use_imm;
        s.write_result = 1'b1;            // flags untouched
        return s;
    endfunction

    function automatic gb_cpu_common_pkg::schedule_t arith8_bit(
        gb_cpu_common_pkg::alu_op_t op,
        gb_cpu_common_pkg::r8_t r8 = gb_cpu_common_pkg::REG_A,
        logic use_imm = 1'b0
    );
        gb_cpu_common_pkg::schedule_t s;
        s              = empty_schedule();
        s.valid        = 1'b1;
        s.alu_op       = op;
        // inc and dec work in place, everything else lands in a
        s.dst          = (op inside {gb_cpu_common_pkg::INC, gb_cpu_common_pkg::DEC})
                         ? r8 : gb_cpu_common_pkg::REG_A;
        s.src          = r8;
        s.use_imm      = use_imm;
        s.write_result = !(op inside {gb_cpu_common_pkg::CP, gb_cpu_common_pkg::SCF,
                                      gb_cpu_common_pkg::CCF});
        s.write_flags  = 1'b1;
        return s;
    endfunction

    function automatic gb_cpu_common_pkg::schedule_t rotate_shift_bit(
        gb_cpu_common_pkg::alu_op_t op,
        gb_cpu_common_pkg::r8_t r8 = gb_cpu_common_pkg::REG_A,
        logic [2:0] bit_idx = 3'd0,
        logic unprefixed = 1'b0
    );
        gb_cpu_common_pkg::schedule_t s;
        s              = empty_schedule();
        s.valid        = 1'b1;
        s.alu_op       = op;
        s.dst          = r8;
        s.src          = r8;
        s.bit_idx      = bit_idx;
        s.write_result = (op != gb_cpu_common_pkg::BIT);
        s.write_flags  = !(op inside {gb_cpu_common_pkg::RES, gb_cpu_common_pkg::SET});
        s.keep_z       = unprefixed;
        return s;
    endfunction

    function automatic gb_cpu_common_pkg::schedule_t misc_op(
        logic halt = 1'b0,
        logic cb_next = 1'b0
    );
        gb_cpu_common_pkg::schedule_t s;
        s         = empty_schedule();
        s.valid   = 1'b1;
        s.alu_op  = gb_cpu_common_pkg::PASS;  // no writes at all
        s.halt    = halt;
        s.cb_next = cb_next;
        return s;
    endfunction

    ////////////////////////////////////////
    // opcode table
    ////////////////////////////////////////

    always_comb begin : decode
        casez ({cb_prefix, opcode})
            9'b1_00_???_???: schedule = rotate_shift_bit(.op(shf_op), .r8(r8_lo));
            9'b1_??_???_???: schedule = rotate_shift_bit(.op(bsr_op), .r8(r8_lo),
                                                         .bit_idx(opcode[5:3]));

            9'b0_00_000_000: schedule = misc_op();                               // nop
            9'b0_00_???_110: schedule = load8_bit(.dst(r8_hi), .use_imm(1'b1));  // ld r8, imm8
            9'b0_01_110_110: schedule = misc_op(.halt(1'b1));                    // halt
            9'b0_01_???_???: schedule = load8_bit(.dst(r8_hi), .src(r8_lo));     // ld r8, r8
            9'b0_10_???_???: schedule = arith8_bit(.op(acc_op), .r8(r8_lo));     // op a, r8
            9'b0_11_???_110: schedule = arith8_bit(.op(acc_op), .use_imm(1'b1)); // op a, imm8
            // inc r8, dec r8
            9'b0_00_???_100: schedule = arith8_bit(.op(gb_cpu_common_pkg::INC), .r8(r8_hi));
            9'b0_00_???_101: schedule = arith8_bit(.op(gb_cpu_common_pkg::DEC), .r8(r8_hi));
            9'b0_00_0??_111: schedule = rotate_shift_bit(.op(shf_op), .unprefixed(1'b1));
            9'b0_00_101_111: schedule = arith8_bit(.op(gb_cpu_common_pkg::CPL));
            9'b0_00_110_111: schedule = arith8_bit(.op(gb_cpu_common_pkg::SCF));
            9'b0_00_111_111: schedule = arith8_bit(.op(gb_cpu_common_pkg::CCF));
            9'b0_11_001_011: schedule = misc_op(.cb_next(1'b1));                 // 0xcb
            default:         schedule = empty_schedule();
        endcase
        // no memory path, any (hl) operand decodes to nothing
        if (schedule.dst == gb_cpu_common_pkg::REG_HL ||
            schedule.src == gb_cpu_common_pkg::REG_HL) begin
            schedule = empty_schedule();
        end
    end : decode

endmodule : gb_cpu_decoder

// ==== gb_cpu_sequencer.sv ====
module gb_cpu_sequencer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         instr_valid,
    input  logic [7:0]                   instr_byte,
    input  gb_cpu_common_pkg::schedule_t schedule,
    output logic [7:0]                   opcode,
    output logic                         cb_prefix,
    output gb_cpu_common_pkg::exec_t     exec,
    output logic                         exec_valid,
    output logic                         busy,
    output logic                         halted
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_CB,
        ST_WAIT_IMM,
        ST_EXEC
    } state_t;

    state_t     state;
    logic [7:0] opcode_q;  // held while the immediate arrives
    logic       take;

    assign busy       = (state == ST_EXEC);
    assign exec_valid = (state == ST_EXEC);
    assign take       = instr_valid && !busy && !halted;

    // decode the byte on the bus, except while waiting for an immediate
    assign opcode    = (state == ST_WAIT_IMM) ? opcode_q : instr_byte;
    assign cb_prefix = (state == ST_WAIT_CB);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= ST_IDLE;
            halted <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take && schedule.cb_next) begin
                        state <= ST_WAIT_CB;
                    end else if (take && schedule.use_imm) begin
                        state <= ST_WAIT_IMM;
                    end else if (take) begin
                        state <= ST_EXEC;
                    end
                end
                ST_WAIT_CB, ST_WAIT_IMM: begin
                    if (take) state <= ST_EXEC;  // cb ops never take an immediate
                end
                default: begin
                    state <= ST_IDLE;            // one exec cycle
                    if (exec.sched.halt) halted <= 1'b1;
                end
            endcase
        end
    end

    // last capture before exec wins
    always_ff @(posedge clk) begin
        if (take) begin
            opcode_q   <= instr_byte;
            exec.sched <= schedule;
            exec.imm8  <= instr_byte;
        end
    end

endmodule : gb_cpu_sequencer

// ==== gb_cpu_alu.sv ====
module gb_cpu_alu (
    input  gb_cpu_common_pkg::exec_t exec,
    input  logic                     exec_valid,
    input  logic [7:0]               op_a,      // dst register
    input  logic [7:0]               op_b,      // src register
    input  logic [7:0]               flags_in,
    output gb_cpu_common_pkg::wb_t   wb
);

    logic [7:0] b_val;
    logic [7:0] res;
    logic [8:0] wide;       // carry or borrow in bit 8
    logic [4:0] half;       // carry or borrow in bit 4
    logic       cy;
    logic       c_in;
    logic       z_res;      // z follows the result
    logic       z, n, h, c;
    logic [7:0] flags_new;

    assign b_val = exec.sched.use_imm ? exec.imm8 : op_b;
    assign c_in  = flags_in[gb_cpu_common_pkg::FLAG_C];

    always_comb begin
        res   = op_a;
        wide  = '0;
        half  = '0;
        cy    = 1'b0;
        z_res = 1'b1;
        z     = flags_in[gb_cpu_common_pkg::FLAG_Z];
        n     = 1'b0;
        h     = 1'b0;
        c     = c_in;    // kept unless the op says otherwise
        case (exec.sched.alu_op)
            gb_cpu_common_pkg::ADD, gb_cpu_common_pkg::ADC: begin
                cy   = (exec.sched.alu_op == gb_cpu_common_pkg::ADC) && c_in;
                wide = {1'b0, op_a} + {1'b0, b_val} + {8'd0, cy};
                half = {1'b0, op_a[3:0]} + {1'b0, b_val[3:0]} + {4'd0, cy};
                res  = wide[7:0];
                h    = half[4];
                c    = wide[8];
            end
            gb_cpu_common_pkg::SUB, gb_cpu_common_pkg::SBC, gb_cpu_common_pkg::CP: begin
                cy   = (exec.sched.alu_op == gb_cpu_common_pkg::SBC) && c_in;
                wide = {1'b0, op_a} - {1'b0, b_val} - {8'd0, cy};
                half = {1'b0, op_a[3:0]} - {1'b0, b_val[3:0]} - {4'd0, cy};
                res  = wide[7:0];  // cp drops it, flags only
                n    = 1'b1;
                h    = half[4];
                c    = wide[8];
            end
            gb_cpu_common_pkg::AND: begin
                res = op_a & b_val;
                h   = 1'b1;
                c   = 1'b0;
            end
            gb_cpu_common_pkg::XOR: begin
                res = op_a ^ b_val;
                c   = 1'b0;
            end
            gb_cpu_common_pkg::OR: begin
                res = op_a | b_val;
                c   = 1'b0;
            end
            gb_cpu_common_pkg::INC: begin
                res = op_a + 8'd1;
                h   = (op_a[3:0] == 4'hf);
            end
            gb_cpu_common_pkg::DEC: begin
                res = op_a - 8'd1;
                n   = 1'b1;
                h   = (op_a[3:0] == 4'h0);
            end
            gb_cpu_common_pkg::CPL: begin
                res   = ~op_a;
                z_res = 1'b0;
                n     = 1'b1;
                h     = 1'b1;
            end
            gb_cpu_common_pkg::SCF: begin
                z_res = 1'b0;
                c     = 1'b1;
            end
            gb_cpu_common_pkg::CCF: begin
                z_res = 1'b0;
                c     = !c_in;
            end
            gb_cpu_common_pkg::RLC: {c, res} = {op_a[7], op_a[6:0], op_a[7]};
            gb_cpu_common_pkg::RRC: {res, c} = {op_a[0], op_a[7:1], op_a[0]};
            gb_cpu_common_pkg::RL:  {c, res} = {op_a, c_in};
            gb_cpu_common_pkg::RR:  {res, c} = {c_in, op_a};
            gb_cpu_common_pkg::SLA: {c, res} = {op_a, 1'b0};
            gb_cpu_common_pkg::SRA: {res, c} = {op_a[7], op_a};
            gb_cpu_common_pkg::SRL: {res, c} = {1'b0, op_a};
            gb_cpu_common_pkg::SWAP: begin
                res = {op_a[3:0], op_a[7:4]};
                c   = 1'b0;
            end
            gb_cpu_common_pkg::BIT: begin
                z_res = 1'b0;
                z     = !op_a[exec.sched.bit_idx];
                h     = 1'b1;
            end
            gb_cpu_common_pkg::RES:  res = op_a & ~(8'd1 << exec.sched.bit_idx);
            gb_cpu_common_pkg::SET:  res = op_a | (8'd1 << exec.sched.bit_idx);
            gb_cpu_common_pkg::PASS: res = b_val;  // loads
            default: ;
        endcase
        if (z_res) z = (res == 8'd0);
        if (exec.sched.keep_z) z = 1'b0;
        flags_new                           = '0;
        flags_new[gb_cpu_common_pkg::FLAG_Z] = z;
        flags_new[gb_cpu_common_pkg::FLAG_N] = n;
        flags_new[gb_cpu_common_pkg::FLAG_H] = h;
        flags_new[gb_cpu_common_pkg::FLAG_C] = c;
    end

    assign wb.we       = exec_valid && exec.sched.valid && exec.sched.write_result;
    assign wb.dst      = exec.sched.dst;
    assign wb.data     = res;
    assign wb.flags_we = exec_valid && exec.sched.valid && exec.sched.write_flags;
    assign wb.flags    = flags_new;

endmodule : gb_cpu_alu

// ==== gb_cpu_regfile.sv ====
module gb_cpu_regfile (
    input  logic                   clk,
    input  logic                   reset,
    input  gb_cpu_common_pkg::r8_t rd_a_sel,
    input  gb_cpu_common_pkg::r8_t rd_b_sel,
    input  gb_cpu_common_pkg::r8_t dbg_sel,
    input  gb_cpu_common_pkg::wb_t wb,
    output logic [7:0]             rd_a,
    output logic [7:0]             rd_b,
    output logic [7:0]             dbg_data,
    output logic [7:0]             flags
);

    logic [7:0] regs [8];  // slot 6 is the (hl) code, stays zero
    logic [7:0] f_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
            f_q <= '0;
        end else begin
            if (wb.we && wb.dst != gb_cpu_common_pkg::REG_HL) begin
                regs[wb.dst] <= wb.data;
            end
            if (wb.flags_we) begin
                f_q <= {wb.flags[7:4], 4'h0};  // low nibble reads zero
            end
        end
    end

    assign rd_a     = regs[rd_a_sel];
    assign rd_b     = regs[rd_b_sel];
    assign dbg_data = regs[dbg_sel];
    assign flags    = f_q;

endmodule : gb_cpu_regfile

// ==== gb_cpu_core.sv ====
module gb_cpu_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instr_valid,
    input  logic [7:0]             instr_byte,
    input  gb_cpu_common_pkg::r8_t dbg_sel,
    output logic                   busy,
    output logic                   halted,
    output logic [7:0]             dbg_data,
    output logic [7:0]             flags
);

    logic [7:0]                   opcode;
    logic                         cb_prefix;
    gb_cpu_common_pkg::schedule_t schedule;
    gb_cpu_common_pkg::exec_t     exec;
    logic                         exec_valid;
    logic [7:0]                   rd_a;        // dst operand
    logic [7:0]                   rd_b;        // src operand
    gb_cpu_common_pkg::wb_t       wb;

    gb_cpu_sequencer i_sequencer (.*);

    gb_cpu_decoder i_decoder (.*);

    gb_cpu_alu i_alu (
        .op_a    (rd_a),
        .op_b    (rd_b),
        .flags_in(flags),
        .*
    );

    gb_cpu_regfile i_regfile (
        .rd_a_sel(exec.sched.dst),
        .rd_b_sel(exec.sched.src),
        .*
    );

endmodule : gb_cpu_core

// ==== tb_gb_cpu_assert.sv ====
module tb_gb_cpu_assert (
    input logic                   clk,
    input logic                   reset,
    input logic                   instr_valid,
    input logic [7:0]             instr_byte,
    input gb_cpu_common_pkg::r8_t dbg_sel,
    input logic                   busy,
    input logic                   halted,
    input logic [7:0]             dbg_data,
    input logic [7:0]             flags
);

    logic [7:0][7:0] m_reg;     // shadow registers, opcode order
    logic [7:0]      m_f;
    logic            m_halted;
    logic            pend;      // exec cycle follows
    logic            pend_cb;
    logic [7:0]      pend_op;
    logic [7:0]      pend_imm;
    logic            want_cb;
    logic            want_imm;
    logic            take;
    logic [7:0][7:0] nxt_reg;
    logic [7:0]      nxt_f;
    logic [7:0]      m_dbg;
    int              errors = 0;

    assign take  = instr_valid && !pend && !m_halted;
    assign m_dbg = m_reg[dbg_sel];

    // {carry out, result} for rlc rrc rl rr sla sra swap srl
    function automatic logic [8:0] shift_result(logic [2:0] sel, logic [7:0] a, logic ci);
        case (sel)
            3'd0:    return {a[7], a[6:0], a[7]};
            3'd1:    return {a[0], a[0], a[7:1]};
            3'd2:    return {a[7], a[6:0], ci};
            3'd3:    return {a[0], ci, a[7:1]};
            3'd4:    return {a[7], a[6:0], 1'b0};
            3'd5:    return {a[0], a[7], a[7:1]};
            3'd6:    return {1'b0, a[3:0], a[7:4]};
            default: return {a[0], 1'b0, a[7:1]};
        endcase
    endfunction

    function automatic logic has_imm(logic [7:0] op);
        return (op[2:0] == 3'd6) && ((op[7:6] == 2'b00 && op[5:3] != 3'd6) || op[7:6] == 2'b11);
    endfunction

    ////////////////////////////////////////
    // reference instruction semantics
    ////////////////////////////////////////

    always_comb begin : model
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] r;
        logic [2:0] d;
        logic [2:0] s;
        logic       ci;
        logic       cy;
        logic       fw;       // flags written
        logic       z, n, h, c;
        d             = pend_op[5:3];
        s             = pend_op[2:0];
        ci            = m_f[4];
        a             = m_reg[7];
        b             = pend_op[6] ? pend_imm : m_reg[s];
        r             = 8'h00;
        cy            = (d == 3'd1 || d == 3'd3) && ci;  // adc, sbc
        {z, n, h, c}  = m_f[7:4];
        fw            = 1'b0;
        nxt_reg       = m_reg;
        if (pend_cb) begin
            a = m_reg[s];
            case (pend_op[7:6])
                2'b00: begin
                    {c, r}     = shift_result(d, a, ci);
                    {z, n, h}  = {r == 8'h00, 2'b00};
                    nxt_reg[s] = r;
                    fw         = 1'b1;
                end
                2'b01: begin
                    {z, n, h} = {!a[d], 2'b01};     // bit keeps c
                    fw        = 1'b1;
                end
                2'b10:   nxt_reg[s] = a & ~(8'h01 << d);
                default: nxt_reg[s] = a | (8'h01 << d);
            endcase
        end else begin
            casez (pend_op)
                8'b01??????: nxt_reg[d] = m_reg[s];  // halt copies slot 6 onto itself
                8'b00???110: nxt_reg[d] = pend_imm;
                8'b00???10?: begin
                    a          = m_reg[d];
                    r          = pend_op[0] ? a - 8'h01 : a + 8'h01;
                    n          = pend_op[0];
                    h          = pend_op[0] ? (a[3:0] == 4'h0) : (a[3:0] == 4'hf);
                    z          = (r == 8'h00);
                    nxt_reg[d] = r;
                    fw         = 1'b1;
                end
                8'b10??????, 8'b11???110: begin
                    case (d)
                        3'd0, 3'd1: begin
                            {c, r} = {1'b0, a} + {1'b0, b} + {8'h00, cy};
                            h      = ({1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'h0, cy}) > 5'h0f;
                            n      = 1'b0;
                        end
                        3'd4: {r, n, h, c} = {a & b, 3'b010};
                        3'd5: {r, n, h, c} = {a ^ b, 3'b000};
                        3'd6: {r, n, h, c} = {a | b, 3'b000};
                        default: begin              // sub, sbc, cp
                            r = a - b - {7'h00, cy};
                            n = 1'b1;
                            h = {1'b0, a[3:0]} < ({1'b0, b[3:0]} + {4'h0, cy});
                            c = {1'b0, a} < ({1'b0, b} + {8'h00, cy});
                        end
                    endcase
                    z  = (r == 8'h00);
                    fw = 1'b1;
                    if (d != 3'd7) nxt_reg[7] = r;
                end
                8'b000??111: begin                  // rlca rrca rla rra
                    {c, r}     = shift_result({1'b0, pend_op[4:3]}, a, ci);
                    {z, n, h}  = 3'b000;
                    nxt_reg[7] = r;
                    fw         = 1'b1;
                end
                8'h2f: begin
                    nxt_reg[7] = ~a;
                    {n, h}     = 2'b11;
                    fw         = 1'b1;
                end
                8'h37: begin
                    {n, h, c} = 3'b001;
                    fw        = 1'b1;
                end
                8'h3f: begin
                    {n, h, c} = {2'b00, !ci};
                    fw        = 1'b1;
                end
                default: ;                          // nop, unknown, halt
            endcase
        end
        nxt_f = fw ? {z, n, h, c, 4'h0} : m_f;
    end : model

    always_ff @(posedge clk) begin
        if (reset) begin
            m_reg    <= '0;
            m_f      <= '0;
            m_halted <= 1'b0;
            pend     <= 1'b0;
            pend_cb  <= 1'b0;
            pend_op  <= '0;
            pend_imm <= '0;
            want_cb  <= 1'b0;
            want_imm <= 1'b0;
        end else begin
            pend <= 1'b0;
            if (pend) begin
                m_reg <= nxt_reg;
                m_f   <= nxt_f;
                if (!pend_cb && pend_op == 8'h76) m_halted <= 1'b1;
            end
            if (take) begin
                if (want_cb) begin
                    pend    <= 1'b1;
                    pend_cb <= 1'b1;
                    pend_op <= instr_byte;
                    want_cb <= 1'b0;
                end else if (want_imm) begin
                    pend     <= 1'b1;
                    pend_imm <= instr_byte;
                    want_imm <= 1'b0;
                end else if (instr_byte == 8'hcb) begin
                    want_cb <= 1'b1;
                end else if (has_imm(instr_byte)) begin
                    want_imm <= 1'b1;
                    pend_cb  <= 1'b0;
                    pend_op  <= instr_byte;
                end else begin
                    pend    <= 1'b1;
                    pend_cb <= 1'b0;
                    pend_op <= instr_byte;
                end
            end
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_dbg: assert property (@(posedge clk) disable iff (reset) dbg_data == m_dbg)
        else begin
            errors++;
            $error("Error dbg_data (dbg_sel %h): got %h, expected %h",
                   $sampled(dbg_sel), $sampled(dbg_data), $sampled(m_dbg));
        end

    a_flags: assert property (@(posedge clk) disable iff (reset) flags == m_f)
        else begin
            errors++;
            $error("Error flags: got %h, expected %h", $sampled(flags), $sampled(m_f));
        end

    // busy only in the cycle after the last byte
    a_busy: assert property (@(posedge clk) disable iff (reset) busy == pend)
        else begin
            errors++;
            $error("Error busy: got %h, expected %h", $sampled(busy), $sampled(pend));
        end

    a_halted: assert property (@(posedge clk) disable iff (reset) halted == m_halted)
        else begin
            errors++;
            $error("Error halted: got %h, expected %h", $sampled(halted), $sampled(m_halted));
        end

endmodule : tb_gb_cpu_assert

// ==== tb_gb_cpu.sv ====
module tb_gb_cpu;

    logic                   clk;
    logic                   reset;
    logic                   instr_valid;
    logic [7:0]             instr_byte;
    gb_cpu_common_pkg::r8_t dbg_sel;
    logic                   busy;
    logic                   halted;
    logic [7:0]             dbg_data;
    logic [7:0]             flags;
    logic [31:0]            lfsr;

    gb_cpu_core i_dut (.*);

    bind gb_cpu_core tb_gb_cpu_assert i_check (.*);

    initial begin : clock
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int n, output logic [7:0] v);
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    task automatic draw_reg(output logic [2:0] r);
        logic [7:0] v;
        do begin
            draw(3, v);
        end while (v[2:0] == 3'd6);  // no (hl) operand
        r = v[2:0];
    endtask

    function automatic logic [7:0] misc_opcode(logic [2:0] sel, logic [1:0] pick);
        case (sel)
            3'd4: return 8'h2f;                                    // cpl
            3'd5: return 8'h37;                                    // scf
            3'd6: return 8'h3f;                                    // ccf
            3'd7: return (pick == 2'd0) ? 8'h00 : (pick == 2'd1) ? 8'hd3 :
                         (pick == 2'd2) ? 8'he4 : 8'hfd;           // nop or unknown
            default: return {3'b000, sel[1:0], 3'b111};            // rlca rrca rla rra
        endcase
    endfunction

    // hold the byte until an edge where the DUT is free
    task automatic send_byte(input logic [7:0] b);
        logic taken;
        instr_valid <= 1'b1;
        instr_byte  <= b;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = !busy && !halted;
            @(posedge clk);
        end
    endtask

    task automatic send_random_instr();
        logic [7:0] v;
        logic [7:0] op;
        logic [7:0] imm;
        logic [2:0] d;
        logic [2:0] s;
        draw(3, v);
        draw(3, op);
        draw_reg(d);
        draw_reg(s);
        draw(8, imm);
        case (v[2:0])
            3'd0: send_byte({2'b01, d, s});                        // ld r, r
            3'd1: begin
                send_byte({2'b00, d, 3'b110});                     // ld r, imm
                send_byte(imm);
            end
            3'd2: send_byte({2'b10, op[2:0], s});
            3'd3: begin
                send_byte({2'b11, op[2:0], 3'b110});
                send_byte(imm);
            end
            3'd4: send_byte({2'b00, d, 2'b10, op[0]});             // inc, dec
            3'd5: send_byte(misc_opcode(op[2:0], imm[1:0]));
            3'd6: begin
                send_byte(8'hcb);
                send_byte({2'b00, op[2:0], s});                    // rotate, shift, swap
            end
            default: begin
                send_byte(8'hcb);
                send_byte({(imm[1:0] == 2'b00) ? 2'b01 : imm[1:0], op[2:0], s});
            end
        endcase
    endtask

    initial begin : sweep
        dbg_sel = gb_cpu_common_pkg::REG_B;
        forever begin
            @(posedge clk);
            dbg_sel <= gb_cpu_common_pkg::r8_t'(dbg_sel + 3'd1);
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin : stimulus
        logic [7:0] v;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr_byte  = 8'h00;
        lfsr        = 32'hf981;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < 8; r++) begin
            if (r != 6) begin
                draw(8, v);
                send_byte({2'b00, r[2:0], 3'b110});
                send_byte(v);
            end
        end
        repeat (400) send_random_instr();
        send_byte(8'h76);                                          // halt
        for (int i = 0; i < 8; i++) begin                          // all refused
            draw(8, v);
            instr_byte <= v;
            @(posedge clk);
        end
        instr_valid <= 1'b0;
        repeat (4) @(posedge clk);
        if (i_dut.i_check.errors == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "assertion errors during the run");
        end
    end

    always @(negedge clk) begin
        if (i_dut.i_check.errors != 0) begin
            $display("Testbench failed");
            $fatal(1, "an assertion on the DUT outputs failed");
        end
    end

    initial begin : watchdog
        #(400 * 3 * 2 * 40);                                       // instrs x cycles x 2 x period
        $display("Testbench failed");
        $fatal(1, "timeout, the run did not finish in time");
    end

endmodule : tb_gb_cpu

// ==== flist.f ====
gb_cpu_common_pkg.sv
gb_cpu_decoder.sv
gb_cpu_sequencer.sv
gb_cpu_alu.sv
gb_cpu_regfile.sv
gb_cpu_core.sv
tb_gb_cpu_assert.sv
tb_gb_cpu.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --assert --timing --top-module tb_gb_cpu -f flist.f \
    && ./obj_dir/Vtb_gb_cpu +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2> /dev/null
grep -q "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
